/* design/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data word width
`define XLEN 32

// architectural registers, register zero reads as zero
`define NUM_REGS 32

// reorder buffer entries, must be a power of two
`define ROB_DEPTH 8

// multiplier latency in cycles
`define MUL_STAGES 3

`endif

/* design/isa_pkg.sv */
`include "core_config.svh"

package isa_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [4:0] reg_idx_t;

	// codes 9 to 15 are undefined and decode as NOP
	typedef enum logic [3:0] {
		NOP  = 4'd0,
		ADD  = 4'd1,
		SUB  = 4'd2,
		AND  = 4'd3,
		OR   = 4'd4,
		XOR  = 4'd5,
		SLL  = 4'd6,
		ADDI = 4'd7,
		MUL  = 4'd8
	} op_t;

	// instruction field positions
	localparam int OPC_HI = 31;
	localparam int OPC_LO = 28;
	localparam int RD_HI  = 27;
	localparam int RD_LO  = 23;
	localparam int RS1_HI = 22;
	localparam int RS1_LO = 18;
	localparam int RS2_HI = 17;
	localparam int RS2_LO = 13;
	localparam int IMM_HI = 12;
	localparam int IMM_LO = 0;
	localparam int IMM_W  = IMM_HI - IMM_LO + 1;

endpackage

/* design/pipe_pkg.sv */
`include "core_config.svh"

package pipe_pkg;

	localparam int ROB_TAG_W = $clog2(`ROB_DEPTH);

	// index of a reorder buffer entry
	typedef logic [ROB_TAG_W-1:0] rob_tag_t;

	// FREE  no instruction
	// WAIT  issued, result pending
	// DONE  result written, ready to retire
	typedef enum logic [1:0] {
		FREE = 2'd0,
		WAIT = 2'd1,
		DONE = 2'd2
	} rob_state_t;

endpackage

/* design/dispatch.sv */
`include "core_config.svh"

module dispatch (
	input  logic               clk,
	input  logic               reset,
	input  logic               instr_valid,
	input  logic [`XLEN-1:0]   instr,
	input  isa_pkg::word_t     instr_pc,
	output logic               stall,
	output isa_pkg::reg_idx_t  rs1_idx,
	output isa_pkg::reg_idx_t  rs2_idx,
	input  isa_pkg::word_t     rs1_data,
	input  isa_pkg::word_t     rs2_data,
	output logic               alloc,
	output isa_pkg::word_t     alloc_pc,
	output isa_pkg::reg_idx_t  alloc_rd,
	output logic               alloc_we,
	input  pipe_pkg::rob_tag_t alloc_tag,
	input  logic               full,
	output logic               issue_valid,
	output isa_pkg::op_t       issue_op,
	output isa_pkg::word_t     issue_a,
	output isa_pkg::word_t     issue_b,
	output pipe_pkg::rob_tag_t issue_tag,
	input  logic               retire_valid,
	input  isa_pkg::reg_idx_t  retire_rd,
	input  logic               retire_we,
	input  pipe_pkg::rob_tag_t retire_tag
);

	logic [3:0]         opc;
	isa_pkg::op_t       op;
	isa_pkg::reg_idx_t  rd;
	isa_pkg::word_t     imm;
	logic               uses_rs1;
	logic               uses_rs2;
	logic               src_busy;
	logic [`NUM_REGS-1:0] busy;
	pipe_pkg::rob_tag_t last_tag [`NUM_REGS];

	// field decode
	assign opc     = instr[isa_pkg::OPC_HI:isa_pkg::OPC_LO];
	assign op      = (opc > isa_pkg::MUL) ? isa_pkg::NOP : isa_pkg::op_t'(opc);
	assign rd      = instr[isa_pkg::RD_HI:isa_pkg::RD_LO];
	assign rs1_idx = instr[isa_pkg::RS1_HI:isa_pkg::RS1_LO];
	assign rs2_idx = instr[isa_pkg::RS2_HI:isa_pkg::RS2_LO];
	assign imm     = {{(`XLEN - isa_pkg::IMM_W){instr[isa_pkg::IMM_HI]}},
		instr[isa_pkg::IMM_HI:isa_pkg::IMM_LO]};

	// only sources the opcode really reads can hold it back
	assign uses_rs1 = (op != isa_pkg::NOP);
	assign uses_rs2 = (op != isa_pkg::NOP) && (op != isa_pkg::ADDI);
	assign src_busy = (uses_rs1 && busy[rs1_idx]) || (uses_rs2 && busy[rs2_idx]);

	assign stall = full || src_busy;
	assign alloc = instr_valid && !stall;

	assign alloc_pc = instr_pc;
	assign alloc_rd = rd;
	assign alloc_we = (op != isa_pkg::NOP) && (rd != '0);

	// issue goes out in the accept cycle, operands straight from the regfile
	assign issue_valid = alloc;
	assign issue_op    = op;
	assign issue_a     = rs1_data;
	assign issue_b     = (op == isa_pkg::ADDI) ? imm : rs2_data;
	assign issue_tag   = alloc_tag;

	// scoreboard, a new writer wins over a same-cycle release
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= '0;
		end else begin
			if (retire_valid && retire_we && last_tag[retire_rd] == retire_tag)
				busy[retire_rd] <= 1'b0;
			if (alloc && alloc_we)
				busy[rd] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (alloc && alloc_we)
			last_tag[rd] <= alloc_tag;
	end

	// a retiring writer still holds its busy bit
	a_retire_was_busy: assert property (@(posedge clk) disable iff (reset)
		retire_valid && retire_we |-> busy[retire_rd]);

endmodule

/* design/exec_units.sv */
`include "core_config.svh"

module exec_units (
	input  logic               clk,
	input  logic               reset,
	input  logic               issue_valid,
	input  isa_pkg::op_t       issue_op,
	input  isa_pkg::word_t     issue_a,
	input  isa_pkg::word_t     issue_b,
	input  pipe_pkg::rob_tag_t issue_tag,
	output logic               alu_done,
	output pipe_pkg::rob_tag_t alu_tag,
	output isa_pkg::word_t     alu_data,
	output logic               mul_done,
	output pipe_pkg::rob_tag_t mul_tag,
	output isa_pkg::word_t     mul_data
);

	logic               to_alu;
	logic               to_mul;
	isa_pkg::word_t     alu_res;
	logic               mul_v    [`MUL_STAGES];
	pipe_pkg::rob_tag_t mul_t    [`MUL_STAGES];
	isa_pkg::word_t     mul_prod [`MUL_STAGES];

	assign to_mul = issue_valid && (issue_op == isa_pkg::MUL);
	assign to_alu = issue_valid && (issue_op != isa_pkg::MUL);

	// nop and undefined codes give zero
	always_comb begin
		case (issue_op)
			isa_pkg::ADD,
			isa_pkg::ADDI: alu_res = issue_a + issue_b;
			isa_pkg::SUB:  alu_res = issue_a - issue_b;
			isa_pkg::AND:  alu_res = issue_a & issue_b;
			isa_pkg::OR:   alu_res = issue_a | issue_b;
			isa_pkg::XOR:  alu_res = issue_a ^ issue_b;
			isa_pkg::SLL:  alu_res = issue_a << issue_b[4:0];
			default:       alu_res = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			alu_done <= 1'b0;
		else
			alu_done <= to_alu;
	end

	always_ff @(posedge clk) begin
		if (to_alu) begin
			alu_tag  <= issue_tag;
			alu_data <= alu_res;
		end
	end

	// multiplier shift pipe, product formed on entry
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `MUL_STAGES; i++)
				mul_v[i] <= 1'b0;
		end else begin
			mul_v[0] <= to_mul;
			for (int i = 1; i < `MUL_STAGES; i++)
				mul_v[i] <= mul_v[i-1];
		end
	end

	always_ff @(posedge clk) begin
		mul_t[0]    <= issue_tag;
		mul_prod[0] <= issue_a * issue_b;
		for (int i = 1; i < `MUL_STAGES; i++) begin
			mul_t[i]    <= mul_t[i-1];
			mul_prod[i] <= mul_prod[i-1];
		end
	end

	assign mul_done = mul_v[`MUL_STAGES-1];
	assign mul_tag  = mul_t[`MUL_STAGES-1];
	assign mul_data = mul_prod[`MUL_STAGES-1];

	// one tag is finished by one unit only
	a_one_unit: assert property (@(posedge clk) disable iff (reset)
		alu_done && mul_done |-> alu_tag != mul_tag);

endmodule

/* design/rob.sv */
`include "core_config.svh"

module rob (
	input  logic               clk,
	input  logic               reset,
	input  logic               alloc,
	input  isa_pkg::word_t     alloc_pc,
	input  isa_pkg::reg_idx_t  alloc_rd,
	input  logic               alloc_we,
	output pipe_pkg::rob_tag_t alloc_tag,
	output logic               full,
	input  logic               alu_done,
	input  pipe_pkg::rob_tag_t alu_tag,
	input  isa_pkg::word_t     alu_data,
	input  logic               mul_done,
	input  pipe_pkg::rob_tag_t mul_tag,
	input  isa_pkg::word_t     mul_data,
	output logic               retire_valid,
	output pipe_pkg::rob_tag_t retire_tag,
	output isa_pkg::word_t     retire_pc,
	output isa_pkg::reg_idx_t  retire_rd,
	output logic               retire_we,
	output isa_pkg::word_t     retire_data
);

	pipe_pkg::rob_state_t state [`ROB_DEPTH];
	isa_pkg::word_t       e_pc   [`ROB_DEPTH];
	isa_pkg::reg_idx_t    e_rd   [`ROB_DEPTH];
	logic                 e_we   [`ROB_DEPTH];
	isa_pkg::word_t       e_data [`ROB_DEPTH];

	pipe_pkg::rob_tag_t head;
	pipe_pkg::rob_tag_t tail;
	logic [$clog2(`ROB_DEPTH):0] count;

	assign full      = (count == `ROB_DEPTH);
	assign alloc_tag = tail;

	// head retires as soon as its result is in
	assign retire_valid = (state[head] == pipe_pkg::DONE);
	assign retire_tag   = head;
	assign retire_pc    = e_pc[head];
	assign retire_rd    = e_rd[head];
	assign retire_we    = e_we[head];
	assign retire_data  = e_data[head];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `ROB_DEPTH; i++)
				state[i] <= pipe_pkg::FREE;
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (retire_valid) begin
				state[head] <= pipe_pkg::FREE;
				head        <= head + 1'b1;
			end
			if (alloc) begin
				state[tail] <= pipe_pkg::WAIT;
				tail        <= tail + 1'b1;
			end
			// both units may finish in one cycle, always on distinct entries
			if (alu_done)
				state[alu_tag] <= pipe_pkg::DONE;
			if (mul_done)
				state[mul_tag] <= pipe_pkg::DONE;
			case ({alloc, retire_valid})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (alloc) begin
			e_pc[tail] <= alloc_pc;
			e_rd[tail] <= alloc_rd;
			e_we[tail] <= alloc_we;
		end
		if (alu_done)
			e_data[alu_tag] <= alu_data;
		if (mul_done)
			e_data[mul_tag] <= mul_data;
	end

	a_alu_to_wait: assert property (@(posedge clk) disable iff (reset)
		alu_done |-> state[alu_tag] == pipe_pkg::WAIT);

	a_mul_to_wait: assert property (@(posedge clk) disable iff (reset)
		mul_done |-> state[mul_tag] == pipe_pkg::WAIT);

	// a done head must be a counted, allocated entry
	a_retire_done: assert property (@(posedge clk) disable iff (reset)
		retire_valid |-> count != 0);

endmodule

/* design/arch_regs.sv */
`include "core_config.svh"

module arch_regs (
	input  logic              clk,
	input  logic              reset,
	input  isa_pkg::reg_idx_t rs1_idx,
	input  isa_pkg::reg_idx_t rs2_idx,
	output isa_pkg::word_t    rs1_data,
	output isa_pkg::word_t    rs2_data,
	input  logic              retire_valid,
	input  isa_pkg::reg_idx_t retire_rd,
	input  logic              retire_we,
	input  isa_pkg::word_t    retire_data
);

	isa_pkg::word_t regs [`NUM_REGS];

	// written only by retiring instructions, so always architectural state
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (retire_valid && retire_we && retire_rd != '0) begin
			regs[retire_rd] <= retire_data;
		end
	end

	// register zero is hardwired
	assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

/* design/core.sv */
`include "core_config.svh"

module core (
	input  logic              clk,
	input  logic              reset,
	input  logic              instr_valid,
	input  logic [`XLEN-1:0]  instr,
	input  isa_pkg::word_t    instr_pc,
	output logic              stall,
	output logic              retire_valid,
	output isa_pkg::word_t    retire_pc,
	output isa_pkg::reg_idx_t retire_rd,
	output logic              retire_we,
	output isa_pkg::word_t    retire_data
);

	isa_pkg::reg_idx_t  rs1_idx;
	isa_pkg::reg_idx_t  rs2_idx;
	isa_pkg::word_t     rs1_data;
	isa_pkg::word_t     rs2_data;
	logic               alloc;
	isa_pkg::word_t     alloc_pc;
	isa_pkg::reg_idx_t  alloc_rd;
	logic               alloc_we;
	pipe_pkg::rob_tag_t alloc_tag;
	logic               full;
	logic               issue_valid;
	isa_pkg::op_t       issue_op;
	isa_pkg::word_t     issue_a;
	isa_pkg::word_t     issue_b;
	pipe_pkg::rob_tag_t issue_tag;
	logic               alu_done;
	pipe_pkg::rob_tag_t alu_tag;
	isa_pkg::word_t     alu_data;
	logic               mul_done;
	pipe_pkg::rob_tag_t mul_tag;
	isa_pkg::word_t     mul_data;
	pipe_pkg::rob_tag_t retire_tag;

	dispatch u_dispatch (
		.clk, .reset,
		.instr_valid, .instr, .instr_pc, .stall,
		.rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
		.alloc, .alloc_pc, .alloc_rd, .alloc_we, .alloc_tag, .full,
		.issue_valid, .issue_op, .issue_a, .issue_b, .issue_tag,
		.retire_valid, .retire_rd, .retire_we, .retire_tag
	);

	exec_units u_exec (
		.clk, .reset,
		.issue_valid, .issue_op, .issue_a, .issue_b, .issue_tag,
		.alu_done, .alu_tag, .alu_data,
		.mul_done, .mul_tag, .mul_data
	);

	rob u_rob (
		.clk, .reset,
		.alloc, .alloc_pc, .alloc_rd, .alloc_we, .alloc_tag, .full,
		.alu_done, .alu_tag, .alu_data,
		.mul_done, .mul_tag, .mul_data,
		.retire_valid, .retire_tag, .retire_pc, .retire_rd, .retire_we, .retire_data
	);

	arch_regs u_regs (
		.clk, .reset,
		.rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
		.retire_valid, .retire_rd, .retire_we, .retire_data
	);

endmodule

/* sim/core_tb.sv */
`include "core_config.svh"

module core_tb;

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		isa_pkg::word_t    pc;
		isa_pkg::reg_idx_t rd;
		logic              we;
		isa_pkg::word_t    data;
	} exp_t;

	logic              clk = 1'b0;
	logic              reset;
	logic              instr_valid;
	logic [`XLEN-1:0]  instr;
	isa_pkg::word_t    instr_pc;
	logic              stall;
	logic              retire_valid;
	isa_pkg::word_t    retire_pc;
	isa_pkg::reg_idx_t retire_rd;
	logic              retire_we;
	isa_pkg::word_t    retire_data;

	integer            seed;
	logic              prog_ready = 1'b0;
	logic [`XLEN-1:0]  prog [$];
	exp_t              exp_q [$];
	isa_pkg::word_t    model_regs [`NUM_REGS];
	int                checks = 0;
	int                value_errors = 0;
	int                other_errors = 0;

	core dut (
		.clk, .reset,
		.instr_valid, .instr, .instr_pc, .stall,
		.retire_valid, .retire_pc, .retire_rd, .retire_we, .retire_data
	);

	always #4 clk = ~clk;

	function automatic int rand_range(int lo, int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	task automatic push_instr(int op, int rd, int rs1, int rs2, int imm);
		prog.push_back({op[3:0], rd[4:0], rs1[4:0], rs2[4:0], imm[12:0]});
	endtask

	// steps the model register file in acceptance order
	function automatic exp_t model_step(logic [`XLEN-1:0] word, isa_pkg::word_t pc);
		exp_t           e;
		logic [3:0]     op;
		isa_pkg::word_t a;
		isa_pkg::word_t b;
		isa_pkg::word_t imm;
		op   = word[31:28];
		a    = model_regs[word[22:18]];
		b    = model_regs[word[17:13]];
		imm  = {{(`XLEN - 13){word[12]}}, word[12:0]};
		e.pc = pc;
		e.rd = word[27:23];
		e.we = (op >= 4'd1) && (op <= 4'd8) && (e.rd != 5'd0);
		case (op)
			isa_pkg::ADD:  e.data = a + b;
			isa_pkg::SUB:  e.data = a - b;
			isa_pkg::AND:  e.data = a & b;
			isa_pkg::OR:   e.data = a | b;
			isa_pkg::XOR:  e.data = a ^ b;
			isa_pkg::SLL:  e.data = a << b[4:0];
			isa_pkg::ADDI: e.data = a + imm;
			isa_pkg::MUL:  e.data = a * b;
			default:       e.data = '0;
		endcase
		if (e.we)
			model_regs[e.rd] = e.data;
		return e;
	endfunction

	// held back while the buffer is full or an unretired writer owns a source
	function automatic logic expect_stall(logic [`XLEN-1:0] word);
		logic [3:0] op;
		logic       reads_rs1;
		logic       reads_rs2;
		logic       hold;
		op        = word[31:28];
		reads_rs1 = (op >= 4'd1) && (op <= 4'd8);
		reads_rs2 = reads_rs1 && (op != 4'd7);
		hold      = (exp_q.size() == `ROB_DEPTH);
		foreach (exp_q[i]) begin
			if (exp_q[i].we && reads_rs1 && exp_q[i].rd == word[22:18])
				hold = 1'b1;
			if (exp_q[i].we && reads_rs2 && exp_q[i].rd == word[17:13])
				hold = 1'b1;
		end
		return hold;
	endfunction

	task automatic build_program();
		// first reads of untouched registers
		push_instr(isa_pkg::OR, 1, 7, 9, 0);
		push_instr(isa_pkg::ADD, 2, 30, 31, 0);
		// random small values, then wider ones from products
		for (int r = 1; r < 16; r++)
			push_instr(isa_pkg::ADDI, r, 0, 0, rand_range(0, 8191));
		for (int r = 16; r < 32; r++)
			push_instr(isa_pkg::MUL, r, rand_range(1, 15), rand_range(1, 15), 0);
		for (int op = isa_pkg::ADD; op <= isa_pkg::MUL; op++)
			push_instr(op, rand_range(1, 31), rand_range(1, 31), rand_range(1, 31),
				rand_range(0, 8191));
		push_instr(isa_pkg::ADDI, 3, 20, 0, -rand_range(1, 4096));
		// dependent chain
		push_instr(isa_pkg::MUL, 10, 17, 18, 0);
		push_instr(isa_pkg::ADD, 11, 10, 19, 0);
		push_instr(isa_pkg::SUB, 12, 11, 10, 0);
		// slow mul ahead of independent alu ops
		push_instr(isa_pkg::MUL, 13, 21, 22, 0);
		push_instr(isa_pkg::ADD, 14, 23, 24, 0);
		push_instr(isa_pkg::XOR, 15, 25, 26, 0);
		push_instr(isa_pkg::SLL, 16, 27, 28, 0);
		// mul burst longer than the reorder buffer
		for (int i = 0; i < `ROB_DEPTH + 4; i++)
			push_instr(isa_pkg::MUL, 17 + i % 8, 1 + i % 8, 9 + i % 6, 0);
		push_instr(isa_pkg::ADD, 0, 1, 2, 0);
		push_instr(isa_pkg::MUL, 0, 3, 4, 0);
		for (int op = 9; op < 16; op++)
			push_instr(op, rand_range(1, 31), rand_range(0, 31), rand_range(0, 31),
				rand_range(0, 8191));
		push_instr(isa_pkg::OR, 20, 0, 0, 0);
		push_instr(isa_pkg::ADDI, 21, 0, 0, 5);
		for (int i = 0; i < 300; i++)
			push_instr(rand_range(0, 15), rand_range(0, 31), rand_range(0, 31),
				rand_range(0, 31), rand_range(0, 8191));
	endtask

	// hold each word until an edge sees it accepted
	task automatic run_program();
		for (int i = 0; i < prog.size(); i++) begin
			instr_valid <= 1'b1;
			instr       <= prog[i];
			instr_pc    <= 32'h1000 + 4 * i;
			do @(posedge clk); while (stall);
		end
		instr_valid <= 1'b0;
	endtask

	always @(posedge clk) begin
		if (!reset && instr_valid && !stall)
			exp_q.push_back(model_step(instr, instr_pc));
	end

	// stall level, checked between edges while a word is offered
	always @(negedge clk) begin
		logic exp_stall;
		if (!reset && instr_valid) begin
			exp_stall = expect_stall(instr);
			assert (stall == exp_stall) else begin
				value_errors++;
				$display("ERROR stall got %h expected %h", stall, exp_stall);
			end
		end
	end

	// in-order comparator
	always @(posedge clk) begin
		exp_t e;
		if (!reset && retire_valid) begin
			assert (exp_q.size() != 0) else begin
				other_errors++;
				$display("retire of pc %h with no accepted instruction left", retire_pc);
			end
			if (exp_q.size() != 0) begin
				e = exp_q.pop_front();
				checks++;
				assert (retire_pc == e.pc) else begin
					value_errors++;
					$display("ERROR retire_pc got %h expected %h", retire_pc, e.pc);
				end
				assert (retire_rd == e.rd) else begin
					value_errors++;
					$display("ERROR retire_rd got %h expected %h", retire_rd, e.rd);
				end
				assert (retire_we == e.we) else begin
					value_errors++;
					$display("ERROR retire_we got %h expected %h", retire_we, e.we);
				end
				assert (retire_data == e.data) else begin
					value_errors++;
					$display("ERROR retire_data got %h expected %h", retire_data, e.data);
				end
			end
		end
	end

	initial begin : watchdog
		int limit;
		wait (prog_ready);
		limit = 200 * prog.size() + 16 + 8;
		repeat (limit) @(posedge clk);
		$display("timeout after %0d cycles, %0d expected retirements never came",
			limit, exp_q.size());
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		seed        = 32'he611f31b;
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		instr_pc    = '0;
		for (int r = 0; r < `NUM_REGS; r++)
			model_regs[r] = '0;
		build_program();
		prog_ready = 1'b1;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		// idle core must not retire anything
		repeat (8) begin
			@(posedge clk);
			assert (!retire_valid) else begin
				other_errors++;
				$display("retire_valid went high before any instruction was accepted");
			end
		end
		run_program();
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (10) @(posedge clk);
		assert (exp_q.size() == 0) else begin
			other_errors++;
			$display("%0d accepted instructions never retired", exp_q.size());
		end
		$display("retired %0d, value errors %0d, other errors %0d",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* build.f */
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/dispatch.sv
design/exec_units.sv
design/rob.sv
design/arch_regs.sv
design/core.sv
sim/core_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := core_tb
FILELIST   := build.f
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
